/* logic/mem_pkg.sv */
package mem_pkg;

	// access width requested by the core
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} mem_size_e;

	// connector request FSM
	typedef enum logic [1:0] {
		S_IDLE = 2'd0,	// no bus cycle
		S_BUS  = 2'd1,	// wishbone cycle in flight
		S_HOLD = 2'd2	// read data held for the core
	} conn_state_e;

	typedef logic [31:0] word_t;	// data word
	typedef logic [31:0] addr_t;	// byte address
	typedef logic [29:0] wb_adr_t;	// word address, byte addr [31:2]
	typedef logic [3:0]  byte_sel_t;	// one bit per byte lane

endpackage

/* logic/wb_bus_if.sv */
interface wb_bus_if;

	logic               cyc;
	logic               stb;
	logic               we;
	mem_pkg::wb_adr_t   adr;
	mem_pkg::byte_sel_t sel;
	mem_pkg::word_t     dat_w;	// master to slave
	mem_pkg::word_t     dat_r;	// slave to master
	logic               ack;

	modport master (
		output cyc, stb, we, adr, sel, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, sel, dat_w,
		output dat_r, ack
	);

endinterface

/* logic/mem_align.sv */
module mem_align (
	input  logic                en_i,
	input  logic [1:0]          addr_lo_i,
	input  mem_pkg::mem_size_e  size_i,
	input  logic                sign_ext_i,
	input  mem_pkg::word_t      data_w_i,
	input  mem_pkg::word_t      bus_data_i,
	output mem_pkg::byte_sel_t  sel_o,
	output mem_pkg::word_t      data_w_o,
	output mem_pkg::word_t      data_r_o,
	output logic                unalign_o
);

	logic [4:0]     shamt;	// bit offset of the addressed lane
	mem_pkg::word_t bus_shifted;

	assign shamt = {addr_lo_i, 3'b000};
	assign bus_shifted = bus_data_i >> shamt;	// addressed field moved to bit 0

	always_comb begin
		sel_o = '0;
		data_w_o = '0;
		data_r_o = '0;
		unalign_o = 1'b0;
		if (en_i) begin
			case (size_i)
				mem_pkg::SIZE_WORD: begin
					if (addr_lo_i != 2'b00) begin
						unalign_o = 1'b1;
					end else begin
						sel_o = 4'b1111;
						data_w_o = data_w_i;
						data_r_o = bus_data_i;
					end
				end
				mem_pkg::SIZE_HALF: begin
					if (addr_lo_i[0]) begin
						unalign_o = 1'b1;	// odd byte
					end else begin
						sel_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
						data_w_o = mem_pkg::word_t'(data_w_i[15:0]) << shamt;
						data_r_o = {{16{sign_ext_i & bus_shifted[15]}}, bus_shifted[15:0]};
					end
				end
				mem_pkg::SIZE_BYTE: begin
					sel_o = 4'b0001 << addr_lo_i;
					data_w_o = mem_pkg::word_t'(data_w_i[7:0]) << shamt;
					data_r_o = {{24{sign_ext_i & bus_shifted[7]}}, bus_shifted[7:0]};
				end
				default: begin
					unalign_o = 1'b0;	// unknown size, no lanes
				end
			endcase
		end
	end

endmodule

/* logic/wb_cpu_conn.sv */
module wb_cpu_conn (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               suspend_i,	// abandon current access
	input  logic               en_r_i,
	input  logic               en_w_i,
	input  mem_pkg::addr_t     addr_i,
	input  mem_pkg::mem_size_e size_i,
	input  logic               sign_ext_i,
	input  mem_pkg::word_t     data_w_i,
	input  logic               lock_i,	// keep result, no repeat access
	output mem_pkg::word_t     data_r_o,
	output logic               stall_o,
	output logic               unalign_o,
	wb_bus_if.master           wb
);

	mem_pkg::conn_state_e state, next_state;
	mem_pkg::byte_sel_t   sel_align;
	mem_pkg::word_t       data_align_w;
	mem_pkg::word_t       data_hold;	// bus read data held for extraction
	logic                 en;
	logic                 req;
	logic                 launch;

	assign en = en_r_i | en_w_i;
	assign req = en & ~unalign_o;
	assign launch = (state == mem_pkg::S_IDLE) && (next_state == mem_pkg::S_BUS);

	mem_align align0 (
		.en_i       (en),
		.addr_lo_i  (addr_i[1:0]),
		.size_i     (size_i),
		.sign_ext_i (sign_ext_i),
		.data_w_i   (data_w_i),
		.bus_data_i (data_hold),
		.sel_o      (sel_align),
		.data_w_o   (data_align_w),
		.data_r_o   (data_r_o),
		.unalign_o  (unalign_o)
	);

	always_comb begin
		next_state = state;
		if (suspend_i) begin
			next_state = mem_pkg::S_IDLE;
		end else begin
			case (state)
				mem_pkg::S_IDLE: if (req) next_state = mem_pkg::S_BUS;
				mem_pkg::S_BUS:  if (wb.ack) next_state = mem_pkg::S_HOLD;
				mem_pkg::S_HOLD: if (!lock_i) next_state = mem_pkg::S_IDLE;
				default:         next_state = mem_pkg::S_IDLE;
			endcase
		end
	end

	// high through the ack cycle, low once data sits in the hold register
	assign stall_o = ~suspend_i &
		((state == mem_pkg::S_BUS) || (next_state == mem_pkg::S_BUS));

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= mem_pkg::S_IDLE;
			wb.cyc <= 1'b0;
			wb.stb <= 1'b0;
			wb.we <= 1'b0;
		end else begin
			state <= next_state;
			if (launch) begin
				wb.cyc <= 1'b1;
				wb.stb <= 1'b1;
				wb.we <= en_w_i;
			end else if (next_state != mem_pkg::S_BUS) begin
				wb.cyc <= 1'b0;	// drop after ack or on suspend
				wb.stb <= 1'b0;
				wb.we <= 1'b0;
			end
		end
	end

	// request fields frozen for the whole transfer
	always_ff @(posedge clk) begin
		if (launch) begin
			wb.adr <= addr_i[31:2];
			wb.sel <= sel_align;
			wb.dat_w <= data_align_w;
		end
		if (state == mem_pkg::S_BUS && next_state == mem_pkg::S_HOLD) begin
			data_hold <= wb.dat_r;
		end
	end

endmodule

/* logic/wb_sram.sv */
module wb_sram #(
	parameter int MEM_WORDS   = 256,
	parameter int WAIT_STATES = 1
) (
	input  logic     clk,
	input  logic     rst_n_i,
	wb_bus_if.slave  wb
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;

	mem_pkg::word_t mem [MEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic [CNT_W-1:0] wait_cnt;
	logic             req;
	logic             last_wait;	// ack goes high next cycle

	assign idx = IDX_W'(wb.adr % mem_pkg::wb_adr_t'(MEM_WORDS));
	assign req = wb.cyc & wb.stb;
	assign last_wait = (WAIT_STATES == 0) || (int'(wait_cnt) == WAIT_STATES - 1);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wait_cnt <= '0;
			wb.ack <= 1'b0;
		end else if (!req || wb.ack) begin
			wait_cnt <= '0;	// idle, abandoned or just acked
			wb.ack <= 1'b0;
		end else if (last_wait) begin
			wait_cnt <= '0;
			wb.ack <= 1'b1;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (req && !wb.ack && last_wait) begin
			wb.dat_r <= mem[idx];	// valid alongside ack
		end
		if (req && wb.ack && wb.we) begin
			for (int i = 0; i < 4; i++) begin
				if (wb.sel[i]) begin
					mem[idx][8*i +: 8] <= wb.dat_w[8*i +: 8];
				end
			end
		end
	end

endmodule

/* logic/mem_subsys_top.sv */
module mem_subsys_top #(
	parameter int MEM_WORDS   = 256,
	parameter int WAIT_STATES = 1
) (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               en_r_i,
	input  logic               en_w_i,
	input  mem_pkg::addr_t     addr_i,
	input  mem_pkg::mem_size_e size_i,
	input  logic               sign_ext_i,
	input  mem_pkg::word_t     data_w_i,
	input  logic               lock_i,
	input  logic               suspend_i,
	output mem_pkg::word_t     data_r_o,
	output logic               stall_o,
	output logic               unalign_o
);

	wb_bus_if wb0 ();	// connector to sram

	wb_cpu_conn conn0 (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.suspend_i  (suspend_i),
		.en_r_i     (en_r_i),
		.en_w_i     (en_w_i),
		.addr_i     (addr_i),
		.size_i     (size_i),
		.sign_ext_i (sign_ext_i),
		.data_w_i   (data_w_i),
		.lock_i     (lock_i),
		.data_r_o   (data_r_o),
		.stall_o    (stall_o),
		.unalign_o  (unalign_o),
		.wb         (wb0.master)
	);

	wb_sram #(
		.MEM_WORDS   (MEM_WORDS),
		.WAIT_STATES (WAIT_STATES)
	) sram0 (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.wb      (wb0.slave)
	);

endmodule

/* verif/clk_gen.sv */
module clk_gen (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_NS = 2;	// 4 ns period

	initial begin
		clk_o = 1'b0;
	end

	always begin
		#(HALF_NS) clk_o = ~clk_o;
	end

endmodule

/* verif/tb_mem_subsys.sv */
module tb_mem_subsys;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_STATES = 2;
	localparam int MAX_RECS    = 64;
	localparam int REC_WORDS   = 8;	// columns per data file line
	localparam int HOLD_CYCLES = 4;	// cycles observed under lock
	localparam int OP_READ     = 0;
	localparam int OP_WRITE    = 1;
	localparam int OP_SUSPEND  = 2;	// write abandoned by suspend

	logic               clk;
	logic               rst_n;
	logic               en_r;
	logic               en_w;
	mem_pkg::addr_t     addr;
	mem_pkg::mem_size_e size;
	logic               sign_ext;
	mem_pkg::word_t     data_w;
	logic               lock;
	logic               suspend;
	mem_pkg::word_t     data_r;
	logic               stall;
	logic               unalign;

	logic [31:0] tdata [REC_WORDS*MAX_RECS];
	int          nrec;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          cycle_limit = 0;

	clk_gen clkgen0 (
		.clk_o (clk)
	);

	mem_subsys_top #(
		.MEM_WORDS   (256),
		.WAIT_STATES (WAIT_STATES)
	) dut0 (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.en_r_i     (en_r),
		.en_w_i     (en_w),
		.addr_i     (addr),
		.size_i     (size),
		.sign_ext_i (sign_ext),
		.data_w_i   (data_w),
		.lock_i     (lock),
		.suspend_i  (suspend),
		.data_r_o   (data_r),
		.stall_o    (stall),
		.unalign_o  (unalign)
	);

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// leading records with a valid op code
	function automatic int count_records();
		int n;
		n = 0;
		while (n < MAX_RECS && tdata[n*REC_WORDS] <= 32'(OP_SUSPEND)) begin
			n++;
		end
		return n;
	endfunction

	task automatic run_access(input int r);
		int          base;
		int          stall_cycles;
		logic [31:0] op;
		logic [31:0] sz;
		logic [31:0] sext;
		logic [31:0] lk;
		logic [31:0] exp_un;
		logic [31:0] exp_rd;
		logic [31:0] exp_stall;
		logic [31:0] held;
		base = r * REC_WORDS;
		op = tdata[base];
		sz = tdata[base + 1];
		sext = tdata[base + 2];
		lk = tdata[base + 3];
		exp_un = tdata[base + 4];
		exp_rd = tdata[base + 7];
		stall_cycles = 0;
		@(posedge clk);
		en_r <= (op == OP_READ);
		en_w <= (op == OP_WRITE);
		addr <= tdata[base + 5];
		size <= mem_pkg::mem_size_e'(sz[1:0]);
		sign_ext <= sext[0];
		data_w <= tdata[base + 6];
		lock <= lk[0];
		@(negedge clk);
		while (stall !== 1'b0) begin
			stall_cycles++;
			@(negedge clk);
		end
		// request cycle, wait states and the ack cycle
		exp_stall = exp_un[0] ? 32'd0 : 32'(WAIT_STATES + 2);
		check($sformatf("stall_o cycles (record %0d)", r), 32'(stall_cycles), exp_stall);
		check($sformatf("unalign_o (record %0d)", r), 32'(unalign), exp_un);
		if (op == OP_READ) begin
			check($sformatf("data_r_o (record %0d)", r), data_r, exp_rd);
		end
		if (lk[0]) begin
			held = data_r;
			repeat (HOLD_CYCLES) begin
				@(posedge clk);
				data_w <= ~data_w;	// a second write would store this
				@(negedge clk);
				check($sformatf("stall_o under lock (record %0d)", r), 32'(stall), 32'd0);
				check($sformatf("data_r_o under lock (record %0d)", r), data_r, held);
			end
		end
		@(posedge clk);
		en_r <= 1'b0;
		en_w <= 1'b0;
		lock <= 1'b0;
	endtask

	task automatic run_suspend(input int r);
		int base;
		base = r * REC_WORDS;
		@(posedge clk);
		en_w <= 1'b1;
		addr <= tdata[base + 5];
		size <= mem_pkg::mem_size_e'(tdata[base + 1][1:0]);
		sign_ext <= 1'b0;
		data_w <= tdata[base + 6];
		lock <= 1'b0;
		@(negedge clk);
		check($sformatf("stall_o before suspend (record %0d)", r), 32'(stall), 32'd1);
		@(posedge clk);
		suspend <= 1'b1;	// cycle on the bus with ack two cycles away
		en_w <= 1'b0;
		@(negedge clk);
		check($sformatf("stall_o on suspend (record %0d)", r), 32'(stall), 32'd0);
		@(posedge clk);
		suspend <= 1'b0;
		@(negedge clk);
		check($sformatf("stall_o after suspend (record %0d)", r), 32'(stall), 32'd0);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: no end of test after %0d cycles, %0d errors so far",
				cycle_limit, errors);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		en_r = 1'b0;
		en_w = 1'b0;
		addr = '0;
		size = mem_pkg::SIZE_WORD;
		sign_ext = 1'b0;
		data_w = '0;
		lock = 1'b0;
		suspend = 1'b0;
		for (int i = 0; i < REC_WORDS*MAX_RECS; i++) begin
			tdata[i] = 32'hdead0000 | 32'(i);
		end
		$readmemh("verif/mem_testdata.txt", tdata);
		nrec = count_records();
		cycle_limit = nrec * (WAIT_STATES + 6) + 50;
		if (nrec == 0) begin
			errors++;
			$display("no records found in verif/mem_testdata.txt");
		end
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int r = 0; r < nrec; r++) begin
			if (tdata[r*REC_WORDS] == OP_SUSPEND) begin
				run_suspend(r);
			end else begin
				run_access(r);
			end
		end
		repeat (2) @(posedge clk);
		$display("%0d records, %0d checks, %0d errors", nrec, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* verif/mem_testdata.txt */
// op (0 read, 1 write, 2 suspended write), size (0 byte, 1 half, 2 word), sign_ext, lock
// expected unalign, byte address, write data, expected read data; all hex
1 2 0 0 0 00000010 12345678 00000000
0 2 0 0 0 00000010 00000000 12345678
1 2 0 0 0 00000024 cafef00d 00000000
0 2 0 0 0 00000024 00000000 cafef00d
1 2 0 0 0 00000030 11223344 00000000
1 0 0 0 0 00000031 000000a5 00000000
1 0 0 0 0 00000033 0000007e 00000000
0 2 0 0 0 00000030 00000000 7e22a544
1 2 0 0 0 00000040 80f17f85 00000000
0 0 1 0 0 00000040 00000000 ffffff85
0 0 0 0 0 00000040 00000000 00000085
0 0 1 0 0 00000042 00000000 fffffff1
0 1 1 0 0 00000042 00000000 ffff80f1
0 1 1 0 0 00000040 00000000 00007f85
0 1 0 0 0 00000042 00000000 000080f1
1 1 0 0 0 00000012 0000beef 00000000
0 2 0 0 0 00000010 00000000 beef5678
1 2 0 0 1 00000011 deadbeef 00000000
1 1 0 0 1 00000013 0000aaaa 00000000
0 2 0 0 1 00000026 00000000 00000000
0 2 0 0 0 00000010 00000000 beef5678
1 2 0 0 0 00000050 0f0f0f0f 00000000
1 2 0 1 0 00000050 5a5a5a5a 00000000
0 2 0 1 0 00000050 00000000 5a5a5a5a
2 2 0 0 0 00000024 00000000 00000000
0 2 0 0 0 00000024 00000000 cafef00d

/* verilog.f */
logic/mem_pkg.sv
logic/wb_bus_if.sv
logic/mem_align.sv
logic/wb_cpu_conn.sv
logic/wb_sram.sv
logic/mem_subsys_top.sv
verif/clk_gen.sv
verif/tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_mem_subsys \
	-f verilog.f -o sim_mem_subsys \
	&& ./obj_dir/sim_mem_subsys | tee sim.log \
	|| { echo "build or simulation failed"; exit 1; }
grep -q "^Done: no errors$" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
